//--- soc_l2_xbar.f
+incdir+logic
logic/soc_l2_pkg.sv
logic/l2_bank_decode.sv
logic/contig_region_decode.sv
logic/tcdm_rr_arb.sv
logic/soc_l2_route.sv
logic/soc_l2_interconnect.sv
dv/soc_l2_tb.sv

//--- Makefile
# Verilator build and run for the L2 crossbar testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := soc_l2_tb
FILELIST  := soc_l2_xbar.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the binary is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/soc_l2_tb.sv
`default_nettype none

`include "soc_l2_defs.svh"

module soc_l2_tb
    import soc_l2_pkg::*;
();

    localparam int NM          = `SOC_L2_NR_MASTERS;
    localparam int NB          = `SOC_L2_NR_BANKS;
    localparam int NC          = `SOC_L2_NR_CONTIG;
    // Port number used for unmapped addresses
    localparam int ERR_PORT    = NB + NC;
    localparam int ROM_PORT    = NB + 2;
    localparam int NR_RANDOM   = 400;
    localparam int NR_HOT      = 80;
    localparam int NR_OPS      = NR_RANDOM + NR_HOT;
    localparam int WAIT_LIMIT  = 64;
    localparam int CYCLE_LIMIT = 20000;

    localparam logic [31:0] L2_START = `SOC_L2_L2_START_ADDR;
    localparam logic [31:0] L2_END   = `SOC_L2_L2_END_ADDR;
    localparam logic [31:0] CONTIG_BASE [NC] = '{
        `SOC_L2_PRIV0_START_ADDR,
        `SOC_L2_PRIV1_START_ADDR,
        `SOC_L2_ROM_START_ADDR
    };
    localparam logic [31:0] CONTIG_LAST [NC] = '{
        `SOC_L2_PRIV0_END_ADDR,
        `SOC_L2_PRIV1_END_ADDR,
        `SOC_L2_ROM_END_ADDR
    };
    // Holes around the mapped regions
    localparam logic [31:0] UNMAPPED_BASE [4] = '{
        32'h0000_0000, 32'h1C09_0000, 32'h1A00_4000, 32'h1BFF_FF00
    };

    logic        clk = 1'b0;
    logic        arst_n;
    tcdm_req_t   mst_req    [NM];
    tcdm_rsp_t   mst_rsp    [NM];
    bank_req_t   l2_req     [NB];
    slv_rsp_t    l2_rsp     [NB];
    contig_req_t contig_req [NC];
    slv_rsp_t    contig_rsp [NC];

    // Reference byte memory and the slaves' word storage
    logic [7:0]  model_mem [logic [31:0]];
    logic [31:0] slv_mem   [logic [31:0]];

    // Per master bookkeeping
    bit          active    [NM];
    bit          pend      [NM];
    bit          pend_chk  [NM];
    logic [31:0] pend_data [NM];
    int          issued    [NM];
    int          wait_cnt  [NM];
    int          rivals    [NM];

    always #4 clk = ~clk;

    soc_l2_interconnect soc_l2_interconnect_inst (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .mst_req_i    (mst_req),
        .mst_rsp_o    (mst_rsp),
        .l2_req_o     (l2_req),
        .l2_rsp_i     (l2_rsp),
        .contig_req_o (contig_req),
        .contig_rsp_i (contig_rsp)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic compare_val(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %08h actual %08h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "aborted");
    endtask

    // Initial memory content, every address bit takes part
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3C;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] wa);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = fill_byte(wa + 32'(i));
        end
        return w;
    endfunction

    function automatic logic [31:0] rom_word(input logic [12:0] w);
        return 32'h5EED_0000 ^ {w, 3'b101, w, 3'b011};
    endfunction

    // Slave port 0..3 banks, 4..6 contiguous, 7 unmapped
    function automatic int port_of(input logic [31:0] a);
        if (a >= L2_START && a <= L2_END) begin
            return int'(a[3:2]);
        end
        for (int c = 0; c < NC; c++) begin
            if (a >= CONTIG_BASE[c] && a <= CONTIG_LAST[c]) begin
                return NB + c;
            end
        end
        return ERR_PORT;
    endfunction

    // Word address as seen at the slave
    function automatic logic [31:0] local_of(input logic [31:0] a, input int p);
        if (p < NB) begin
            return (a - L2_START) >> 4;
        end
        if (p < ERR_PORT) begin
            return (a - CONTIG_BASE[p - NB]) >> 2;
        end
        return '0;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = model_mem.exists(a + 32'(i)) ? model_mem[a + 32'(i)]
                                                      : fill_byte(a + 32'(i));
        end
        return w;
    endfunction

    function automatic logic [31:0] slave_word(input logic [31:0] ga);
        return slv_mem.exists(ga) ? slv_mem[ga] : fill_word(ga);
    endfunction

    function automatic logic [31:0] apply_be(input logic [31:0] old,
                                             input logic [31:0] wdata,
                                             input logic [3:0]  be);
        logic [31:0] w;
        w = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return w;
    endfunction

    ////////////////////
    // Slave models
    ////////////////////

    always @(posedge clk or negedge arst_n) begin
        logic [31:0] ga;
        if (!arst_n) begin
            for (int b = 0; b < NB; b++) begin
                l2_rsp[b] <= '0;
            end
            for (int c = 0; c < NC; c++) begin
                contig_rsp[c] <= '0;
            end
        end else begin
            for (int b = 0; b < NB; b++) begin
                // Bank b row w holds global word L2_START + w*16 + b*4
                ga = L2_START + ((32'(l2_req[b].addr) << 4) | (32'(b) << 2));
                l2_rsp[b].r_valid <= l2_req[b].req & l2_rsp[b].gnt;
                if (l2_req[b].req && l2_rsp[b].gnt) begin
                    if (l2_req[b].wen) begin
                        l2_rsp[b].r_rdata <= slave_word(ga);
                    end else begin
                        slv_mem[ga] = apply_be(slave_word(ga), l2_req[b].wdata,
                                               l2_req[b].be);
                    end
                end
                // Random stalls
                l2_rsp[b].gnt <= ($urandom % 4) != 0;
            end
            for (int c = 0; c < NC; c++) begin
                ga = CONTIG_BASE[c] + (32'(contig_req[c].addr) << 2);
                contig_rsp[c].r_valid <= contig_req[c].req & contig_rsp[c].gnt;
                if (contig_req[c].req && contig_rsp[c].gnt) begin
                    if (c == 2) begin
                        // Boot ROM, writes have no effect
                        contig_rsp[c].r_rdata <= rom_word(contig_req[c].addr);
                    end else if (contig_req[c].wen) begin
                        contig_rsp[c].r_rdata <= slave_word(ga);
                    end else begin
                        slv_mem[ga] = apply_be(slave_word(ga), contig_req[c].wdata,
                                               contig_req[c].be);
                    end
                end
                contig_rsp[c].gnt <= ($urandom % 4) != 0;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic logic [31:0] region_addr(input logic [31:0] start,
                                                input logic [31:0] last,
                                                input logic [31:0] idx);
        // Near the start or near the end of the region
        return (($urandom % 2) != 0) ? start + (idx << 2) : last - 32'd3 - (idx << 2);
    endfunction

    function automatic tcdm_req_t make_request(input int m);
        tcdm_req_t   r;
        logic [31:0] idx;
        int          kind;
        idx  = $urandom % 48;
        kind = int'($urandom % 8);
        if (issued[m] >= NR_RANDOM) begin
            // Both masters pile onto bank 1
            r.addr = L2_START + ((idx << 4) | 32'h4);
        end else begin
            case (kind)
                0, 1, 2, 3: r.addr = region_addr(L2_START, L2_END, idx);
                4:       r.addr = region_addr(CONTIG_BASE[0], CONTIG_LAST[0], idx);
                5:       r.addr = region_addr(CONTIG_BASE[1], CONTIG_LAST[1], idx);
                6:       r.addr = region_addr(CONTIG_BASE[2], CONTIG_LAST[2], idx);
                default: r.addr = UNMAPPED_BASE[2'($urandom)] + (idx << 2);
            endcase
        end
        r.req   = 1'b1;
        r.wen   = 1'($urandom % 2);
        // Partial byte enables now and then
        r.be    = (($urandom % 3) == 0) ? 4'($urandom) : 4'hF;
        r.wdata = $urandom;
        issued[m]++;
        active[m]   = 1'b1;
        wait_cnt[m] = 0;
        rivals[m]   = 0;
        return r;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    // Granted request must sit at its own slave port, with the local address
    task automatic check_slave_port(input int m, input int p);
        string       tag;
        logic [31:0] loc;
        tag = $sformatf("m%0d port %0d", m, p);
        loc = local_of(mst_req[m].addr, p);
        if (p < NB) begin
            compare_val({tag, " accept"}, 32'd1, 32'(l2_req[p].req & l2_rsp[p].gnt));
            compare_val({tag, " addr"}, loc, 32'(l2_req[p].addr));
            compare_val({tag, " wen"}, 32'(mst_req[m].wen), 32'(l2_req[p].wen));
            compare_val({tag, " be"}, 32'(mst_req[m].be), 32'(l2_req[p].be));
            if (!mst_req[m].wen) begin
                compare_val({tag, " wdata"}, mst_req[m].wdata, l2_req[p].wdata);
            end
        end else if (p < ERR_PORT) begin
            compare_val({tag, " accept"}, 32'd1,
                        32'(contig_req[p - NB].req & contig_rsp[p - NB].gnt));
            compare_val({tag, " addr"}, loc, 32'(contig_req[p - NB].addr));
            compare_val({tag, " wen"}, 32'(mst_req[m].wen), 32'(contig_req[p - NB].wen));
            compare_val({tag, " be"}, 32'(mst_req[m].be), 32'(contig_req[p - NB].be));
            if (!mst_req[m].wen) begin
                compare_val({tag, " wdata"}, mst_req[m].wdata, contig_req[p - NB].wdata);
            end
        end
    endtask

    // Expected response, and the model takes the write at gnt
    task automatic record_grant(input int m, input int p);
        logic [31:0] a;
        a            = mst_req[m].addr;
        active[m]    = 1'b0;
        pend[m]      = 1'b1;
        pend_chk[m]  = mst_req[m].wen || (p == ERR_PORT);
        pend_data[m] = '0;
        if (p == ERR_PORT) begin
            pend_data[m] = `SOC_L2_ERR_RDATA;
        end else if (p == ROM_PORT) begin
            pend_data[m] = rom_word(13'(local_of(a, p)));
        end else if (mst_req[m].wen) begin
            pend_data[m] = model_word(a);
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (mst_req[m].be[i]) begin
                    model_mem[a + 32'(i)] = mst_req[m].wdata[8*i +: 8];
                end
            end
        end
    endtask

    task automatic check_cycle();
        int port [NM];
        int accepted;
        int expected;
        accepted = 0;
        expected = 0;
        for (int b = 0; b < NB; b++) begin
            if (l2_req[b].req && l2_rsp[b].gnt) accepted++;
        end
        for (int c = 0; c < NC; c++) begin
            if (contig_req[c].req && contig_rsp[c].gnt) accepted++;
        end
        // r_valid exactly one cycle after gnt
        for (int m = 0; m < NM; m++) begin
            port[m] = port_of(mst_req[m].addr);
            compare_val($sformatf("m%0d r_valid", m), 32'(pend[m]),
                        32'(mst_rsp[m].r_valid));
            if (pend[m] && pend_chk[m]) begin
                compare_val($sformatf("m%0d r_rdata", m), pend_data[m],
                            mst_rsp[m].r_rdata);
            end
            pend[m] = 1'b0;
        end
        for (int m = 0; m < NM; m++) begin
            if (!active[m]) begin
                compare_val($sformatf("m%0d idle gnt", m), 32'd0, 32'(mst_rsp[m].gnt));
            end else if (mst_rsp[m].gnt) begin
                if (port[m] != ERR_PORT) expected++;
                check_slave_port(m, port[m]);
                record_grant(m, port[m]);
            end else begin
                // Unmapped gets gnt in the request cycle
                if (port[m] == ERR_PORT) begin
                    compare_val($sformatf("m%0d unmapped gnt", m), 32'd1, 32'd0);
                end
                for (int o = 0; o < NM; o++) begin
                    if (o != m && mst_req[o].req && mst_rsp[o].gnt && port[o] == port[m]) begin
                        rivals[m]++;
                    end
                end
                compare_val($sformatf("m%0d round-robin", m), 32'd1, 32'(rivals[m] <= 1));
                wait_cnt[m]++;
                if (wait_cnt[m] >= WAIT_LIMIT) begin
                    abort_run($sformatf("Master %0d saw no gnt within %0d cycles",
                                        m, WAIT_LIMIT));
                end
            end
        end
        // Nothing shows up at a port it does not belong to
        compare_val("slave accepts", 32'(expected), 32'(accepted));
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int cycle;
        bit busy;
        void'($urandom(32'h1910_e0a3));
        arst_n <= 1'b1;
        for (int m = 0; m < NM; m++) begin
            mst_req[m] <= '0;
            active[m]  = 1'b0;
            pend[m]    = 1'b0;
            issued[m]  = 0;
        end
        #1;
        arst_n <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        cycle = 0;
        busy  = 1'b1;
        while (busy) begin
            @(posedge clk);
            for (int m = 0; m < NM; m++) begin
                if (!active[m]) begin
                    if (issued[m] < NR_OPS) begin
                        mst_req[m] <= make_request(m);
                    end else begin
                        mst_req[m].req <= 1'b0;
                    end
                end
            end
            // Outputs settled well away from the edge
            @(negedge clk);
            check_cycle();
            busy = 1'b0;
            for (int m = 0; m < NM; m++) begin
                if (active[m] || pend[m] || issued[m] < NR_OPS) busy = 1'b1;
            end
            cycle++;
            if (cycle >= CYCLE_LIMIT) begin
                abort_run("Run did not finish within the cycle limit");
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/soc_l2_interconnect.sv
`default_nettype none

`include "soc_l2_defs.svh"

// L2 memory crossbar top
module soc_l2_interconnect
    import soc_l2_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    // Master side
    input  tcdm_req_t   mst_req_i    [`SOC_L2_NR_MASTERS],
    output tcdm_rsp_t   mst_rsp_o    [`SOC_L2_NR_MASTERS],
    // Interleaved L2 banks
    output bank_req_t   l2_req_o     [`SOC_L2_NR_BANKS],
    input  slv_rsp_t    l2_rsp_i     [`SOC_L2_NR_BANKS],
    // Private banks and boot ROM
    output contig_req_t contig_req_o [`SOC_L2_NR_CONTIG],
    input  slv_rsp_t    contig_rsp_i [`SOC_L2_NR_CONTIG]
);

    // Decode results, both computed in the request cycle
    l2_hit_t     l2_hit     [`SOC_L2_NR_MASTERS];
    contig_hit_t contig_hit [`SOC_L2_NR_MASTERS];

    ////////////////////
    // Address decode
    ////////////////////

    l2_bank_decode l2_bank_decode_inst (
        .mst_req_i (mst_req_i),
        .l2_hit_o  (l2_hit)
    );

    contig_region_decode contig_region_decode_inst (
        .mst_req_i    (mst_req_i),
        .contig_hit_o (contig_hit)
    );

    ////////////////////
    // Routing
    ////////////////////

    soc_l2_route soc_l2_route_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .mst_req_i    (mst_req_i),
        .l2_hit_i     (l2_hit),
        .contig_hit_i (contig_hit),
        .mst_rsp_o    (mst_rsp_o),
        .l2_req_o     (l2_req_o),
        .l2_rsp_i     (l2_rsp_i),
        .contig_req_o (contig_req_o),
        .contig_rsp_i (contig_rsp_i)
    );

endmodule

`default_nettype wire

//--- logic/soc_l2_route.sv
`default_nettype none

`include "soc_l2_defs.svh"

// Per slave arbitration, request forwarding and response return
module soc_l2_route
    import soc_l2_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  tcdm_req_t   mst_req_i    [`SOC_L2_NR_MASTERS],
    input  l2_hit_t     l2_hit_i     [`SOC_L2_NR_MASTERS],
    input  contig_hit_t contig_hit_i [`SOC_L2_NR_MASTERS],
    output tcdm_rsp_t   mst_rsp_o    [`SOC_L2_NR_MASTERS],
    output bank_req_t   l2_req_o     [`SOC_L2_NR_BANKS],
    input  slv_rsp_t    l2_rsp_i     [`SOC_L2_NR_BANKS],
    output contig_req_t contig_req_o [`SOC_L2_NR_CONTIG],
    input  slv_rsp_t    contig_rsp_i [`SOC_L2_NR_CONTIG]
);

    localparam int NM = `SOC_L2_NR_MASTERS;
    localparam int NB = `SOC_L2_NR_BANKS;
    localparam int NC = `SOC_L2_NR_CONTIG;

    // One-hot winner per slave port
    logic [NM-1:0] l2_grant     [NB];
    logic [NM-1:0] contig_grant [NC];

    ////////////////////
    // Interleaved banks
    ////////////////////

    for (genvar b = 0; b < NB; b++) begin : g_bank
        logic [NM-1:0] req_vec;
        bank_req_t     slv_req;

        always_comb begin
            for (int m = 0; m < NM; m++) begin
                req_vec[m] = mst_req_i[m].req & l2_hit_i[m].hit &
                             (l2_hit_i[m].bank == 2'(b));
            end
        end

        // Slave gnt acknowledges the arbiter choice
        tcdm_rr_arb #(
            .NR_REQ (NM)
        ) tcdm_rr_arb_inst (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (req_vec),
            .ack_i    (l2_rsp_i[b].gnt),
            .grant_o  (l2_grant[b])
        );

        // Winner payload with the bank local word address
        always_comb begin
            slv_req = '0;
            for (int m = 0; m < NM; m++) begin
                if (l2_grant[b][m]) begin
                    slv_req.req   = 1'b1;
                    slv_req.wen   = mst_req_i[m].wen;
                    slv_req.be    = mst_req_i[m].be;
                    slv_req.wdata = mst_req_i[m].wdata;
                    slv_req.addr  = l2_hit_i[m].addr;
                end
            end
        end

        assign l2_req_o[b] = slv_req;
    end

    ////////////////////
    // Contiguous slaves
    ////////////////////

    for (genvar c = 0; c < NC; c++) begin : g_contig
        logic [NM-1:0] req_vec;
        contig_req_t   slv_req;

        always_comb begin
            for (int m = 0; m < NM; m++) begin
                req_vec[m] = mst_req_i[m].req & contig_hit_i[m].hit &
                             (contig_hit_i[m].idx == 2'(c));
            end
        end

        tcdm_rr_arb #(
            .NR_REQ (NM)
        ) tcdm_rr_arb_inst (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (req_vec),
            .ack_i    (contig_rsp_i[c].gnt),
            .grant_o  (contig_grant[c])
        );

        always_comb begin
            slv_req = '0;
            for (int m = 0; m < NM; m++) begin
                if (contig_grant[c][m]) begin
                    slv_req.req   = 1'b1;
                    slv_req.wen   = mst_req_i[m].wen;
                    slv_req.be    = mst_req_i[m].be;
                    slv_req.wdata = mst_req_i[m].wdata;
                    slv_req.addr  = contig_hit_i[m].addr;
                end
            end
        end

        assign contig_req_o[c] = slv_req;
    end

    ////////////////////
    // Master side
    ////////////////////

    for (genvar m = 0; m < NM; m++) begin : g_mst
        logic      l2_gnt;
        logic      contig_gnt;
        logic      err_req;
        src_t      src_d;
        src_t      src_q;
        tcdm_rsp_t rsp;

        // Neither decoder claims it, router answers itself
        assign err_req = mst_req_i[m].req & ~l2_hit_i[m].hit & ~contig_hit_i[m].hit;

        // Granted when this master won a port and that slave accepted
        always_comb begin
            l2_gnt     = 1'b0;
            contig_gnt = 1'b0;
            for (int b = 0; b < NB; b++) begin
                l2_gnt = l2_gnt | (l2_grant[b][m] & l2_rsp_i[b].gnt);
            end
            for (int c = 0; c < NC; c++) begin
                contig_gnt = contig_gnt | (contig_grant[c][m] & contig_rsp_i[c].gnt);
            end
        end

        // Remember the source of an accepted access
        always_comb begin
            src_d = '{kind: SRC_NONE, idx: 2'd0};
            if (l2_gnt) begin
                src_d = '{kind: SRC_L2, idx: l2_hit_i[m].bank};
            end else if (contig_gnt) begin
                src_d = '{kind: SRC_CONTIG, idx: contig_hit_i[m].idx};
            end else if (err_req) begin
                src_d = '{kind: SRC_ERR, idx: 2'd0};
            end
        end

        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                src_q <= '{kind: SRC_NONE, idx: 2'd0};
            end else begin
                src_q <= src_d;
            end
        end

        // Response steered by last cycle's source
        always_comb begin
            rsp.gnt     = l2_gnt | contig_gnt | err_req;
            rsp.r_valid = 1'b0;
            rsp.r_rdata = '0;
            case (src_q.kind)
                SRC_L2: begin
                    rsp.r_valid = l2_rsp_i[src_q.idx].r_valid;
                    rsp.r_rdata = l2_rsp_i[src_q.idx].r_rdata;
                end
                SRC_CONTIG: begin
                    // Index 3 never decodes, guard the array bound
                    if (int'(src_q.idx) < NC) begin
                        rsp.r_valid = contig_rsp_i[src_q.idx].r_valid;
                        rsp.r_rdata = contig_rsp_i[src_q.idx].r_rdata;
                    end
                end
                SRC_ERR: begin
                    rsp.r_valid = 1'b1;
                    rsp.r_rdata = `SOC_L2_ERR_RDATA;
                end
                default: begin
                end
            endcase
        end

        assign mst_rsp_o[m] = rsp;
    end

endmodule

`default_nettype wire

//--- logic/tcdm_rr_arb.sv
`default_nettype none

// Round-robin arbiter for one slave port
module tcdm_rr_arb #(
    parameter int NR_REQ = 2
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic [NR_REQ-1:0] req_i,
    input  logic              ack_i,
    output logic [NR_REQ-1:0] grant_o
);

    localparam int PTR_W = (NR_REQ > 1) ? $clog2(NR_REQ) : 1;

    // Highest priority position
    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] win_idx;
    logic             found;

    // First requester at or after the pointer, wrapping around
    always_comb begin
        int idx;

        grant_o = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < NR_REQ; i++) begin
            idx = (int'(ptr_q) + i) % NR_REQ;
            if (!found && req_i[idx]) begin
                found        = 1'b1;
                grant_o[idx] = 1'b1;
                win_idx      = PTR_W'(idx);
            end
        end
    end

    // Pointer moves past the winner only once the slave accepted
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (ack_i && found) begin
            ptr_q <= (int'(win_idx) == NR_REQ - 1) ? '0 : win_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/contig_region_decode.sv
`default_nettype none

`include "soc_l2_defs.svh"

// Decode of the contiguous slaves, private banks and boot ROM
module contig_region_decode
    import soc_l2_pkg::*;
(
    input  tcdm_req_t   mst_req_i    [`SOC_L2_NR_MASTERS],
    output contig_hit_t contig_hit_o [`SOC_L2_NR_MASTERS]
);

    localparam int NM     = `SOC_L2_NR_MASTERS;
    localparam int NC     = `SOC_L2_NR_CONTIG;
    localparam int ADDR_W = `SOC_L2_ADDR_W;
    localparam int CA_W   = `SOC_L2_CONTIG_ADDR_W;

    // Region table, index equals slave port
    localparam logic [ADDR_W-1:0] REGION_START [NC] = '{
        `SOC_L2_PRIV0_START_ADDR,
        `SOC_L2_PRIV1_START_ADDR,
        `SOC_L2_ROM_START_ADDR
    };
    localparam logic [ADDR_W-1:0] REGION_END [NC] = '{
        `SOC_L2_PRIV0_END_ADDR,
        `SOC_L2_PRIV1_END_ADDR,
        `SOC_L2_ROM_END_ADDR
    };

    for (genvar m = 0; m < NM; m++) begin : g_mst
        always_comb begin
            logic [ADDR_W-1:0] offset;

            // Miss by default
            contig_hit_o[m] = '0;
            offset          = '0;
            // Walk backwards so the lowest matching index wins
            for (int r = NC - 1; r >= 0; r--) begin
                if ((mst_req_i[m].addr >= REGION_START[r]) &&
                    (mst_req_i[m].addr <= REGION_END[r])) begin
                    offset               = mst_req_i[m].addr - REGION_START[r];
                    contig_hit_o[m].hit  = 1'b1;
                    contig_hit_o[m].idx  = 2'(r);
                    // Word offset, boot ROM leaves the top bit zero
                    contig_hit_o[m].addr = offset[CA_W+1:2];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/l2_bank_decode.sv
`default_nettype none

`include "soc_l2_defs.svh"

// Word interleaved decode of the L2 region, one lane per master
module l2_bank_decode
    import soc_l2_pkg::*;
(
    input  tcdm_req_t mst_req_i [`SOC_L2_NR_MASTERS],
    output l2_hit_t   l2_hit_o  [`SOC_L2_NR_MASTERS]
);

    localparam int NM     = `SOC_L2_NR_MASTERS;
    localparam int ADDR_W = `SOC_L2_ADDR_W;
    localparam int BA_W   = `SOC_L2_BANK_ADDR_W;

    localparam logic [ADDR_W-1:0] L2_START = `SOC_L2_L2_START_ADDR;
    localparam logic [ADDR_W-1:0] L2_END   = `SOC_L2_L2_END_ADDR;

    for (genvar m = 0; m < NM; m++) begin : g_mst
        // Byte offset into the interleaved region
        logic [ADDR_W-1:0] offset;
        logic              in_range;

        assign offset   = mst_req_i[m].addr - L2_START;
        // Inclusive bounds on both ends
        assign in_range = (mst_req_i[m].addr >= L2_START) &&
                          (mst_req_i[m].addr <= L2_END);

        // Bank from the two lowest word bits
        // Region start is bank aligned so this equals addr[3:2]
        assign l2_hit_o[m].hit  = in_range;
        assign l2_hit_o[m].bank = offset[3:2];
        // Remaining word bits address the row inside the bank
        assign l2_hit_o[m].addr = offset[BA_W+3:4];
    end

endmodule

`default_nettype wire

//--- logic/soc_l2_pkg.sv
`default_nettype none

`include "soc_l2_defs.svh"

package soc_l2_pkg;

    // Master request, held until gnt
    typedef struct packed {
        logic                         req;
        logic                         wen;   // High for a read
        logic [3:0]                   be;
        logic [`SOC_L2_ADDR_W-1:0]    addr;
        logic [`SOC_L2_DATA_W-1:0]    wdata;
    } tcdm_req_t;

    // Response back to a master
    typedef struct packed {
        logic                         gnt;
        logic                         r_valid;
        logic [`SOC_L2_DATA_W-1:0]    r_rdata;
    } tcdm_rsp_t;

    // Request towards one interleaved bank
    typedef struct packed {
        logic                             req;
        logic                             wen;
        logic [3:0]                       be;
        logic [`SOC_L2_DATA_W-1:0]        wdata;
        logic [`SOC_L2_BANK_ADDR_W-1:0]   addr;
    } bank_req_t;

    // Request towards one contiguous slave
    typedef struct packed {
        logic                             req;
        logic                             wen;
        logic [3:0]                       be;
        logic [`SOC_L2_DATA_W-1:0]        wdata;
        logic [`SOC_L2_CONTIG_ADDR_W-1:0] addr;
    } contig_req_t;

    // Answer of any slave port
    typedef struct packed {
        logic                         gnt;
        logic                         r_valid;
        logic [`SOC_L2_DATA_W-1:0]    r_rdata;
    } slv_rsp_t;

    // Interleaved decode result
    typedef struct packed {
        logic                             hit;
        logic [1:0]                       bank;
        logic [`SOC_L2_BANK_ADDR_W-1:0]   addr;
    } l2_hit_t;

    // Contiguous decode result
    typedef struct packed {
        logic                             hit;
        logic [1:0]                       idx;
        logic [`SOC_L2_CONTIG_ADDR_W-1:0] addr;
    } contig_hit_t;

    // Where the next response of a master comes from
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_L2,
        SRC_CONTIG,
        SRC_ERR
    } src_kind_t;

    typedef struct packed {
        src_kind_t  kind;
        logic [1:0] idx;
    } src_t;

endpackage

`default_nettype wire

//--- logic/soc_l2_defs.svh
`ifndef SOC_L2_DEFS_SVH
`define SOC_L2_DEFS_SVH

////////////////////
// Port counts
////////////////////

// Masters issuing TCDM requests
`define SOC_L2_NR_MASTERS     2
// Word interleaved L2 banks
`define SOC_L2_NR_BANKS       4
// Private bank 0, private bank 1, boot ROM
`define SOC_L2_NR_CONTIG      3

// Bus widths
`define SOC_L2_ADDR_W         32
`define SOC_L2_DATA_W         32
// Word address inside one interleaved bank
`define SOC_L2_BANK_ADDR_W    15
// Word address inside one contiguous slave
`define SOC_L2_CONTIG_ADDR_W  13

////////////////////
// Memory map
////////////////////

`define SOC_L2_L2_START_ADDR     32'h1C01_0000
`define SOC_L2_L2_END_ADDR       32'h1C08_FFFF
`define SOC_L2_PRIV0_START_ADDR  32'h1C00_0000
`define SOC_L2_PRIV0_END_ADDR    32'h1C00_7FFF
`define SOC_L2_PRIV1_START_ADDR  32'h1C00_8000
`define SOC_L2_PRIV1_END_ADDR    32'h1C00_FFFF
`define SOC_L2_ROM_START_ADDR    32'h1A00_0000
`define SOC_L2_ROM_END_ADDR      32'h1A00_3FFF

// Read data returned for unmapped addresses
`define SOC_L2_ERR_RDATA         32'hBADA_CCE5

`endif
